//--- bench/tb_util.svh
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// 32-bit xorshift step, stays nonzero for a nonzero state
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// expected dot product
// each lane product is formed at 32 bits, then summed at result width
function automatic result_t ref_dot(input operand_vec_t va, input operand_vec_t vb);
  result_t  acc;
  product_t p;
  acc = '0;
  for (int i = 0; i < `CNN_LANES; i++) begin
    p   = product_t'(va[i]) * product_t'(vb[i]); // sign extended before multiply
    acc = acc + result_t'(p);
  end
  return acc;
endfunction

// every lane set to the same value
function automatic operand_vec_t fill_vec(input operand_t v);
  operand_vec_t r;
  for (int i = 0; i < `CNN_LANES; i++) begin
    r[i] = v;
  end
  return r;
endfunction

// a single nonzero lane
function automatic operand_vec_t lane_vec(input int lane, input operand_t v);
  operand_vec_t r;
  r = '0;
  r[lane] = v;
  return r;
endfunction

`endif

//--- bench/tb_cnn_dot16.sv
`timescale 1ns/1ps

`include "cnn_defs.svh"

module tb_cnn_dot16
  import cnn_pkg::*;
();

  localparam int TIMEOUT      = 1000;
  localparam int READY_HIGH   = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_LOW    = 2;

  logic         clk;
  logic         rst_n;
  logic         a_valid;
  logic         b_valid;
  logic         a_ready;
  logic         b_ready;
  operand_vec_t in_a;
  operand_vec_t in_b;
  result_t      re;
  logic         re_valid;
  logic         re_ready;

  logic [31:0]  rng_state = 32'd48067;
  int           ready_mode = READY_HIGH;
  result_t      exp_q[$];
  int           cycle = 0;
  int           acc_edge = 0;
  int           sent = 0;
  int           seen = 0;
  int           stalls = 0;
  logic         hold_pending = 1'b0;
  result_t      held_re = '0;

  `include "tb_util.svh"

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // random lanes with the extremes mixed in
  function automatic operand_vec_t rand_vec();
    operand_vec_t v;
    logic [31:0]  r;
    for (int i = 0; i < `CNN_LANES; i++) begin
      r = rand32();
      case (r[31:29])
        3'd0:    v[i] = 16'sh8000;
        3'd1:    v[i] = 16'sh7fff;
        default: v[i] = r[15:0];
      endcase
    end
    return v;
  endfunction

  cnn_dot16 cnn_dot16_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .a_valid  (a_valid),
    .a_ready  (a_ready),
    .in_a     (in_a),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .in_b     (in_b),
    .re       (re),
    .re_valid (re_valid),
    .re_ready (re_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // result side ready, high, random or held low
  initial begin
    logic [31:0] bp_state;
    bp_state = xorshift(32'd48067);
    re_ready = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      case (ready_mode)
        READY_RANDOM: begin
          bp_state = xorshift(bp_state);
          re_ready = (bp_state[2:0] < 3'd3); // high about 3 cycles in 8
        end
        READY_LOW: re_ready = 1'b0;
        default:   re_ready = 1'b1;
      endcase
    end
  end

  // everything sampled mid-cycle, a transfer happens on the next rising edge
  always @(negedge clk) begin
    result_t expected;
    if (!rst_n) begin
      assert (re_valid === 1'b0) else stop_run("re_valid high during reset");
      hold_pending = 1'b0;
    end else begin
      assert (a_ready === b_ready)
        else stop_run($sformatf("mismatch b_ready: expected %h got %h", a_ready, b_ready));
      if (hold_pending) begin
        assert (re_valid === 1'b1) else stop_run("re_valid dropped while re_ready was low");
        assert (re === held_re)
          else stop_run($sformatf("mismatch re: expected %h got %h", held_re, re));
      end
      if (re_valid === 1'b1 && re_ready === 1'b1) begin
        assert (exp_q.size() > 0) else stop_run("result appeared with no vector outstanding");
        expected = exp_q.pop_front();
        assert (re === expected)
          else stop_run($sformatf("mismatch re: expected %h got %h", expected, re));
        seen++;
      end
      hold_pending = re_valid && !re_ready;
      held_re      = re;
    end
  end

  // holds the pair until accepted, returns 1 ns after the accepting edge
  task automatic send_vec(input operand_vec_t va, input operand_vec_t vb);
    int waited;
    in_a    = va;
    in_b    = vb;
    a_valid = 1'b1;
    b_valid = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (a_ready !== 1'b1) begin
      waited++;
      assert (waited < TIMEOUT) else stop_run("timeout waiting for a_ready");
      @(negedge clk);
    end
    exp_q.push_back(ref_dot(va, vb));
    acc_edge = cycle + 1;
    sent++;
    stalls += waited;
    @(posedge clk);
    #1;
    a_valid = 1'b0;
    b_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      assert (waited < TIMEOUT) else stop_run("timeout waiting for results to drain");
      @(posedge clk);
      #1;
    end
  endtask

  // one channel valid alone must never be taken
  task automatic single_side(input bit side_a, input int n);
    in_a    = rand_vec();
    in_b    = rand_vec();
    a_valid = side_a;
    b_valid = !side_a;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      assert (a_ready === 1'b1) else stop_run("a_ready low with an empty pipeline");
      @(posedge clk);
      #1;
    end
    a_valid = 1'b0;
    b_valid = 1'b0;
  endtask

  initial begin
    operand_vec_t va;
    operand_vec_t vb;
    int           waited;
    int           lat;
    int           fills;
    rst_n   = 1'b0;
    a_valid = 1'b0;
    b_valid = 1'b0;
    in_a    = '0;
    in_b    = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (re_valid === 1'b0) else stop_run("re_valid high right after reset");
    @(posedge clk);
    #1;

    // single vector latency
    send_vec(fill_vec(16'sd1), fill_vec(16'sd1));
    waited = 0;
    @(negedge clk);
    while (re_valid !== 1'b1) begin
      waited++;
      assert (waited < TIMEOUT) else stop_run("timeout waiting for re_valid");
      @(negedge clk);
    end
    lat = cycle + 1 - acc_edge;
    assert (lat == 5) else stop_run($sformatf("mismatch latency: expected %h got %h", 5, lat));
    @(posedge clk);
    #1;
    wait_drain();

    // directed vectors
    assert (ref_dot(fill_vec(16'sd1), fill_vec(16'sd1)) == result_t'(16))
      else stop_run("reference result for all ones is not 16");
    assert (ref_dot(fill_vec(16'sh8000), fill_vec(16'sh8000)) == (result_t'(1) <<< 34))
      else stop_run("reference result for all -32768 is not 2^34");
    for (int i = 0; i < `CNN_LANES; i++) begin
      va[i] = operand_t'((i % 2) ? -(i * 1000 + 7) : (i * 1000 + 7));
      vb[i] = operand_t'((i % 2) ? (3000 - i * 11) : -(3000 - i * 11));
    end
    send_vec(va, vb);
    send_vec(fill_vec(16'sh8000), fill_vec(16'sh8000)); // full width
    for (int i = 0; i < `CNN_LANES; i++) begin
      va[i] = (i % 3 == 0) ? 16'sh7fff : 16'sh8000;
      vb[i] = (i % 2 == 1) ? 16'sh7fff : 16'sh8000;
    end
    send_vec(va, vb);
    for (int k = 0; k < `CNN_LANES; k++) begin
      send_vec(lane_vec(k, operand_t'(k * 2000 - 32000)), lane_vec(k, operand_t'(-(k + 3))));
    end
    wait_drain();

    // join rule
    single_side(1'b1, 6);
    single_side(1'b0, 6);
    idle_cycles(8);
    assert (seen == sent)
      else stop_run($sformatf("mismatch result count: expected %h got %h", sent, seen));

    // pipeline fills to five items with re_ready low
    ready_mode = READY_LOW;
    idle_cycles(1);
    fills   = 0;
    va      = rand_vec();
    vb      = rand_vec();
    in_a    = va;
    in_b    = vb;
    a_valid = 1'b1;
    b_valid = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      if (a_ready === 1'b1) begin
        exp_q.push_back(ref_dot(va, vb));
        sent++;
        fills++;
        va = rand_vec();
        vb = rand_vec();
      end
      @(posedge clk);
      #1;
      in_a = va;
      in_b = vb;
    end
    assert (fills == 5) else stop_run($sformatf("mismatch accepts: expected %h got %h", 5, fills));
    ready_mode = READY_HIGH;
    send_vec(va, vb); // the refused pair goes once the stall clears
    wait_drain();

    // back to back streaming
    for (int n = 0; n < 200; n++) begin
      send_vec(rand_vec(), rand_vec());
    end
    wait_drain();

    // random back-pressure and input gaps
    ready_mode = READY_RANDOM;
    stalls     = 0;
    for (int n = 0; n < 200; n++) begin
      idle_cycles(int'(rand32() % 32'd3));
      send_vec(rand_vec(), rand_vec());
    end
    wait_drain();
    ready_mode = READY_HIGH;
    assert (stalls > 0) else stop_run("back-pressure never reached the inputs");

    idle_cycles(4);
    assert (seen == sent)
      else stop_run($sformatf("mismatch result count: expected %h got %h", sent, seen));
    $display("TEST OK");
    $finish;
  end

endmodule

//--- include/cnn_defs.svh
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// element pairs in one input vector
`define CNN_LANES 16

`define CNN_OP_W 16 // signed two's complement operand

// full signed product of two operands
`define CNN_PROD_W (2 * `CNN_OP_W)

// adder tree depth, log2 of lane count
`define CNN_LEVELS 4

// one extra bit per tree level
`define CNN_RES_W (`CNN_PROD_W + `CNN_LEVELS)

`endif

//--- run.sh
#!/bin/sh
# build and run the cnn_dot16 testbench with Verilator
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cnn_dot16 \
  -f sources.f \
  -o tb_cnn_dot16
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_cnn_dot16
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0

//--- sources.f
+incdir+include
+incdir+bench
verilog/cnn_pkg.sv
verilog/mul_stage.sv
verilog/add_level.sv
verilog/cnn_dot16.sv
bench/tb_cnn_dot16.sv

//--- verilog/add_level.sv
`timescale 1ns/1ps

module add_level #(
  parameter  int N_IN  = 2,
  parameter  int IN_W  = 32,
  localparam int N_OUT = N_IN / 2
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // N_IN signed values of IN_W bits
  input  logic [N_IN-1:0][IN_W-1:0]   in_data,
  input  logic                        in_valid,
  output logic                        in_ready,

  // pairwise sums, one bit wider
  output logic [N_OUT-1:0][IN_W:0]    out_data,
  output logic                        out_valid,
  input  logic                        out_ready
);

  logic [N_OUT-1:0][IN_W:0] sum;
  logic                     accept;

  // lanes 2i and 2i+1 feed output lane i
  for (genvar i = 0; i < N_OUT; i++) begin : g_pair
    assign sum[i] = $signed(in_data[2*i]) + $signed(in_data[2*i+1]);
  end

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid; // empty unless refilled
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= sum;
    end
  end

endmodule

//--- verilog/cnn_dot16.sv
`timescale 1ns/1ps

`include "cnn_defs.svh"

module cnn_dot16
  import cnn_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  input  logic         a_valid,
  output logic         a_ready,
  input  operand_vec_t in_a,

  input  logic         b_valid,
  output logic         b_ready,
  input  operand_vec_t in_b,

  output result_t      re,
  output logic         re_valid,
  input  logic         re_ready
);

  // bit offset of link k in the flat data bus
  // link 0 carries the products, link k the sums of level k-1
  function automatic int lvl_off(input int k);
    int off;
    off = 0;
    for (int j = 0; j < k; j++) begin
      off += (`CNN_LANES >> j) * (`CNN_PROD_W + j);
    end
    return off;
  endfunction

  localparam int BUS_W = lvl_off(`CNN_LEVELS + 1);

  wire [BUS_W-1:0]       lnk_data;
  wire [`CNN_LEVELS:0]   lnk_valid;
  wire [`CNN_LEVELS:0]   lnk_ready;
  wire                   join_ready;

  // one ready serves both input channels
  assign a_ready = join_ready;
  assign b_ready = join_ready;

  mul_stage mul_stage_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_valid    (a_valid),
    .b_valid    (b_valid),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_ready   (join_ready),
    .prod       (lnk_data[0 +: `CNN_LANES*`CNN_PROD_W]),
    .prod_valid (lnk_valid[0]),
    .prod_ready (lnk_ready[0])
  );

  // 16 -> 8 -> 4 -> 2 -> 1
  for (genvar lv = 0; lv < `CNN_LEVELS; lv++) begin : g_level
    localparam int N_IN   = `CNN_LANES >> lv;
    localparam int IN_W   = `CNN_PROD_W + lv;
    localparam int IN_LO  = lvl_off(lv);
    localparam int OUT_LO = lvl_off(lv + 1);

    add_level #(
      .N_IN (N_IN),
      .IN_W (IN_W)
    ) add_level_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_data   (lnk_data[IN_LO +: N_IN*IN_W]),
      .in_valid  (lnk_valid[lv]),
      .in_ready  (lnk_ready[lv]),
      .out_data  (lnk_data[OUT_LO +: (N_IN/2)*(IN_W+1)]),
      .out_valid (lnk_valid[lv+1]),
      .out_ready (lnk_ready[lv+1])
    );
  end

  // last level holds a single sum of result width
  assign re       = lnk_data[lvl_off(`CNN_LEVELS) +: `CNN_RES_W];
  assign re_valid = lnk_valid[`CNN_LEVELS];

  assign lnk_ready[`CNN_LEVELS] = re_ready;

endmodule

//--- verilog/cnn_pkg.sv
`include "cnn_defs.svh"

package cnn_pkg;

  // scalar lane types
  typedef logic signed [`CNN_OP_W-1:0]   operand_t;
  typedef logic signed [`CNN_PROD_W-1:0] product_t;
  typedef logic signed [`CNN_RES_W-1:0]  result_t;

  // lane 0 sits in the low bits
  typedef operand_t [`CNN_LANES-1:0] operand_vec_t;
  typedef product_t [`CNN_LANES-1:0] product_vec_t;

endpackage

//--- verilog/mul_stage.sv
`timescale 1ns/1ps

`include "cnn_defs.svh"

module mul_stage
  import cnn_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,

  // a and b channels, joined into one transfer
  input  logic         a_valid,
  input  logic         b_valid,
  input  operand_vec_t in_a,
  input  operand_vec_t in_b,
  output logic         in_ready, // shared by both channels

  // products towards the first adder level
  output product_vec_t prod,
  output logic         prod_valid,
  input  logic         prod_ready
);

  logic         pair_valid;
  logic         accept;
  product_vec_t prod_next;

  // both operands must be present on the same edge
  assign pair_valid = a_valid && b_valid;

  // register free, or its content leaves this cycle
  assign in_ready = !prod_valid || prod_ready;

  assign accept = pair_valid && in_ready;

  // one signed multiplier per lane
  for (genvar i = 0; i < `CNN_LANES; i++) begin : g_lane
    assign prod_next[i] = in_a[i] * in_b[i]; // operands sign extend to 32 bits
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else if (in_ready) begin
      // load on accept, drop to empty once consumed
      prod_valid <= pair_valid;
    end
  end

  // payload only, no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      prod <= prod_next;
    end
  end

endmodule
